//--- uart_link_top.f
rtl/uart_cfg_pkg.sv
rtl/uart_msg_pkg.sv
rtl/tx_req_if.sv
rtl/uart_tx.sv
rtl/uart_rx.sv
rtl/tx_arbiter.sv
rtl/code_streamer.sv
rtl/echo_responder.sv
rtl/uart_link_top.sv
dv/uart_link_tb.sv

//--- dv/uart_link_input.txt
// one word per line as byte_flag_level in hex: the link byte sent on rx, a flag that is 1
// when the byte goes out with bad parity, and the stream_on level expected after the byte
41_0_1  // echo
7f_0_1  // echo
05_0_1  // code kind, ignored by the responder
55_1_1  // echo with bad parity, never echoed
c0_1_1  // stop with bad parity, ignored
8a_1_1  // set code with bad parity, ignored
4c_0_1  // echo
c0_0_0  // stop
40_0_0  // echo while stopped
be_0_0  // set code 62
c1_0_1  // start, codes 62, 63, 0
63_0_1  // echo
c2_0_0  // stop, only payload bit 0 counts
c3_0_1  // start, resumes from the next code
7e_0_1  // echo

//--- dv/uart_link_tb.sv
`timescale 1ns/1ps
`default_nettype none

module uart_link_tb;

    localparam int bit_clks = uart_cfg_pkg::clks_per_bit;
    localparam int frame_clks = bit_clks * uart_cfg_pkg::frame_bits;
    localparam int stim_depth = 64;

    logic clk;
    logic reset;
    logic rx;
    logic tx;
    logic parity_error;
    logic stream_on;

    logic [15:0] stim [stim_depth];
    logic [7:0] echo_q [$];
    logic [5:0] exp_code;
    int code_frames;
    int pe_count;
    logic mon_active;
    int mon_cnt;
    logic [10:0] mon_bits;

    uart_link_top dut_i (
        .clk          (clk),
        .reset        (reset),
        .rx           (rx),
        .tx           (tx),
        .parity_error (parity_error),
        .stream_on    (stream_on)
    );

    always #10 clk = ~clk;

    task automatic mismatch(input string name, input int expected, input int actual);
        $display("[FAIL] %s: expected %0h, actual %0h", name, expected, actual);
        $display("Testbench failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic halt(input string what);
        $display("ERROR: %s", what);
        $display("Testbench failed");
        $fatal(1, "stopped at the first error");
    endtask

    // sends one frame on rx, LSB first, with even parity unless bad is set
    task automatic send_byte(input logic [7:0] b, input logic bad);
        logic [10:0] bits;
        int i;
        bits = {1'b1, (^b) ^ bad, b, 1'b0};
        for (i = 0; i < 11; i++) begin
            rx = bits[i];
            repeat (bit_clks) @(posedge clk);
            #2;
        end
    endtask

    // codes must run on without a gap, echoes must come out in the order they went in
    task automatic check_frame(input logic [10:0] bits);
        logic [7:0] b;
        b = bits[8:1];
        assert (bits[0] === 1'b0) else halt("a tx start bit was high again at mid-bit");
        assert (bits[9] === ^b) else mismatch("tx parity", ^b, bits[9]);
        assert (bits[10] === 1'b1) else mismatch("tx stop bit", 1, bits[10]);
        assert (b[7:6] == uart_msg_pkg::kind_code || b[7:6] == uart_msg_pkg::kind_echo)
            else halt($sformatf("a command byte %02h appeared on tx", b));
        case (b[7:6])
            uart_msg_pkg::kind_code: begin
                assert (b[5:0] === exp_code) else mismatch("stream code", exp_code, b[5:0]);
                exp_code = exp_code + 1'b1;
                code_frames = code_frames + 1;
            end
            uart_msg_pkg::kind_echo: begin
                assert (echo_q.size() > 0) else halt("an echo frame came out with none pending");
                assert (b === echo_q[0]) else mismatch("echo byte", echo_q[0], b);
                b = echo_q.pop_front();
            end
        endcase
    endtask

    task automatic wait_codes(input int count);
        int target;
        int clks;
        target = code_frames + count;
        clks = 0;
        while (code_frames < target) begin
            @(posedge clk);
            clks = clks + 1;
            if (clks > (2 * count + 2) * frame_clks) begin
                halt("timed out waiting for code frames on tx");
            end
        end
        #2;
    endtask

    task automatic wait_echoes();
        int clks;
        clks = 0;
        while (echo_q.size() > 0) begin
            @(posedge clk);
            clks = clks + 1;
            if (clks > 4 * frame_clks) begin
                halt("timed out waiting for the pending echo frames");
            end
        end
        #2;
    endtask

    // at most one code may still drain after a stop, then the line stays free of codes
    task automatic check_quiet();
        int c0;
        c0 = code_frames;
        repeat (3 * frame_clks) @(posedge clk);
        assert (code_frames - c0 <= 1) else mismatch("codes after stop", 1, code_frames - c0);
        c0 = code_frames;
        repeat (30 * frame_clks) @(posedge clk);
        #2;
        assert (code_frames == c0) else mismatch("codes while stopped", c0, code_frames);
        assert (stream_on === 1'b0) else mismatch("stream_on while stopped", 0, stream_on);
    endtask

    always @(negedge clk) begin
        if (reset) begin
            mon_active = 1'b0;
            pe_count = 0;
        end else begin
            if (parity_error === 1'b1) begin
                pe_count = pe_count + 1;
            end
            if (!mon_active) begin
                if (tx === 1'b0) begin
                    mon_active = 1'b1;
                    mon_cnt = 0;
                end
            end else begin
                mon_cnt = mon_cnt + 1;
                if (mon_cnt % bit_clks == bit_clks / 2) begin
                    mon_bits[mon_cnt / bit_clks] = tx;
                    if (mon_cnt / bit_clks == 10) begin
                        mon_active = 1'b0;
                        check_frame(mon_bits);
                    end
                end
            end
        end
    end

    initial begin
        int n;
        int pe0;
        logic [15:0] w;
        logic [7:0] b;
        logic bad;
        logic exp_on;
        clk = 1'b0;
        reset = 1'b1;
        rx = 1'b1;
        exp_code = '0;
        code_frames = 0;
        // unused entries carry their own index over a flag digit of f, which ends the list
        for (n = 0; n < stim_depth; n++) begin
            stim[n] = {8'(n), 8'hff};
        end
        $readmemh("dv/uart_link_input.txt", stim);
        repeat (10) @(posedge clk);
        #2;
        reset = 1'b0;

        // the line has to stay idle through the start-up delay
        repeat (60) begin
            @(negedge clk);
            assert (tx === 1'b1) else mismatch("tx idle after reset", 1, tx);
        end
        @(posedge clk);
        #2;
        wait_codes(3);

        n = 0;
        while (n < stim_depth && stim[n][7:4] !== 4'hf) begin
            w = stim[n];
            b = w[15:8];
            bad = w[4];
            exp_on = w[0];
            pe0 = pe_count;
            if (!bad && b[7:6] == uart_msg_pkg::kind_echo) begin
                echo_q.push_back(b);
            end
            if (!bad && b[7:6] == uart_msg_pkg::kind_set_code) begin
                exp_code = b[5:0];
            end
            send_byte(b, bad);
            assert (pe_count == pe0 + bad)
                else mismatch("parity_error pulses", pe0 + bad, pe_count);
            assert (stream_on === exp_on) else mismatch("stream_on", exp_on, stream_on);
            if (!bad && b[7:6] == uart_msg_pkg::kind_stream_ctl) begin
                if (b[0]) begin
                    wait_codes(3);
                end else begin
                    check_quiet();
                end
            end
            // one idle frame keeps echo bytes two frame times apart
            repeat (frame_clks) @(posedge clk);
            #2;
            n = n + 1;
        end

        wait_echoes();
        wait_codes(2);
        $display("Testbench passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- rtl/uart_link_top.sv
`timescale 1ns/1ps
`default_nettype none

module uart_link_top (
    input  logic clk,
    input  logic reset,
    input  logic rx,
    output logic tx,
    output logic parity_error,
    output logic stream_on
);

    logic [uart_cfg_pkg::data_bits-1:0] rx_data;
    logic rx_done;
    logic code_load;
    logic [uart_msg_pkg::code_w-1:0] code_value;
    logic tx_start;
    logic [uart_cfg_pkg::data_bits-1:0] tx_data;
    logic tx_busy;

    // one request channel per byte source
    tx_req_if stream_if ();
    tx_req_if echo_if ();

    uart_rx u_rx (
        .clk          (clk),
        .reset        (reset),
        .rx           (rx),
        .data         (rx_data),
        .done         (rx_done),
        .parity_error (parity_error)
    );

    echo_responder u_echo (
        .clk        (clk),
        .reset      (reset),
        .rx_data    (rx_data),
        .rx_done    (rx_done),
        .stream_on  (stream_on),
        .code_load  (code_load),
        .code_value (code_value),
        .req        (echo_if.requester)
    );

    code_streamer u_stream (
        .clk        (clk),
        .reset      (reset),
        .stream_on  (stream_on),
        .code_load  (code_load),
        .code_value (code_value),
        .req        (stream_if.requester)
    );

    tx_arbiter u_arb (
        .clk    (clk),
        .reset  (reset),
        .busy   (tx_busy),
        .start  (tx_start),
        .data   (tx_data),
        .stream (stream_if.arbiter),
        .echo   (echo_if.arbiter)
    );

    uart_tx u_tx (
        .clk   (clk),
        .reset (reset),
        .start (tx_start),
        .data  (tx_data),
        .tx    (tx),
        .busy  (tx_busy)
    );

endmodule

`default_nettype wire

//--- rtl/echo_responder.sv
`timescale 1ns/1ps
`default_nettype none

module echo_responder (
    input  logic clk,
    input  logic reset,
    input  logic [uart_cfg_pkg::data_bits-1:0] rx_data,
    input  logic rx_done,
    output logic stream_on,
    output logic code_load,
    output logic [uart_msg_pkg::code_w-1:0] code_value,
    tx_req_if.requester req
);

    uart_msg_pkg::link_byte_u rx_byte;
    logic [uart_cfg_pkg::data_bits-1:0] hold;
    logic req_q;
    logic slot_free;

    always_comb begin
        rx_byte.raw = rx_data;
    end

    assign req.req = req_q;
    assign req.data = hold;

    // the byte is taken in the grant cycle, so the slot can refill right then
    assign slot_free = !req_q || req.grant;

    always_ff @(posedge clk) begin
        if (reset) begin
            req_q <= 1'b0;
            stream_on <= 1'b1;
            code_load <= 1'b0;
        end else begin
            code_load <= 1'b0;
            if (req.grant) begin
                req_q <= 1'b0;
            end
            if (rx_done) begin
                case (rx_byte.f.kind)
                    uart_msg_pkg::kind_echo: begin
                        // with the holding register full the new echo is lost
                        if (slot_free) begin
                            req_q <= 1'b1;
                        end
                    end
                    uart_msg_pkg::kind_set_code: begin
                        code_load <= 1'b1;
                    end
                    uart_msg_pkg::kind_stream_ctl: begin
                        stream_on <= rx_byte.f.payload[0];
                    end
                    default: begin
                        // code bytes coming back in are not acted on
                    end
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rx_done && rx_byte.f.kind == uart_msg_pkg::kind_echo && slot_free) begin
            hold <= rx_byte.raw;
        end
        if (rx_done && rx_byte.f.kind == uart_msg_pkg::kind_set_code) begin
            code_value <= rx_byte.f.payload;
        end
    end

endmodule

`default_nettype wire

//--- rtl/code_streamer.sv
`timescale 1ns/1ps
`default_nettype none

module code_streamer (
    input  logic clk,
    input  logic reset,
    input  logic stream_on,
    input  logic code_load,
    input  logic [uart_msg_pkg::code_w-1:0] code_value,
    tx_req_if.requester req
);

    logic [uart_cfg_pkg::startup_w-1:0] startup_cnt;
    logic started;
    logic [uart_msg_pkg::code_w-1:0] code;
    logic req_q;
    logic waiting;
    logic load_pend;
    logic [uart_msg_pkg::code_w-1:0] load_val;
    logic can_offer;
    uart_msg_pkg::link_byte_u code_byte;

    always_comb begin
        code_byte.f.kind = uart_msg_pkg::kind_code;
        code_byte.f.payload = code;
    end

    assign req.req = req_q;
    assign req.data = code_byte.raw;

    // a new code goes out only once the previous one has left the line
    assign can_offer = started && stream_on && !req_q && (!waiting || req.sent);

    always_ff @(posedge clk) begin
        if (reset) begin
            startup_cnt <= '0;
            started <= 1'b0;
            code <= '0;
            req_q <= 1'b0;
            waiting <= 1'b0;
            load_pend <= 1'b0;
        end else begin
            if (!started) begin
                startup_cnt <= startup_cnt + 1'b1;
                if (startup_cnt == uart_cfg_pkg::startup_last) begin
                    started <= 1'b1;
                end
            end

            if (req.sent) begin
                waiting <= 1'b0;
            end

            if (can_offer) begin
                req_q <= 1'b1;
            end

            if (req_q && req.grant) begin
                req_q <= 1'b0;
                waiting <= 1'b1;
                load_pend <= 1'b0;
                // a held load replaces the increment, and the 6-bit code wraps by itself
                if (code_load) begin
                    code <= code_value;
                end else if (load_pend) begin
                    code <= load_val;
                end else begin
                    code <= code + 1'b1;
                end
            end else if (code_load) begin
                // data has to stay put while the request is outstanding
                if (req_q) begin
                    load_pend <= 1'b1;
                end else begin
                    code <= code_value;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (code_load && req_q && !req.grant) begin
            load_val <= code_value;
        end
    end

endmodule

`default_nettype wire

//--- rtl/tx_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module tx_arbiter (
    input  logic clk,
    input  logic reset,
    input  logic busy,
    output logic start,
    output logic [uart_cfg_pkg::data_bits-1:0] data,
    tx_req_if.arbiter stream,
    tx_req_if.arbiter echo
);

    logic start_d;
    logic busy_d;
    logic prio_echo;
    logic owner_echo;
    logic line_free;
    logic pick_echo;
    logic line_done;

    // busy only rises the cycle after start, so that cycle is blocked as well
    assign line_free = !busy && !start_d;

    // round robin: the echo wins a tie only when it is its turn
    assign pick_echo = echo.req && (!stream.req || prio_echo);

    assign stream.grant = line_free && stream.req && !pick_echo;
    assign echo.grant = line_free && pick_echo;

    assign start = stream.grant || echo.grant;
    assign data = pick_echo ? echo.data : stream.data;

    // the falling edge of busy marks the end of the owner's stop bit
    assign line_done = busy_d && !busy;
    assign stream.sent = line_done && !owner_echo;
    assign echo.sent = line_done && owner_echo;

    always_ff @(posedge clk) begin
        if (reset) begin
            start_d <= 1'b0;
            busy_d <= 1'b0;
            prio_echo <= 1'b0;
            owner_echo <= 1'b0;
        end else begin
            start_d <= start;
            busy_d <= busy;
            if (start) begin
                owner_echo <= pick_echo;
                prio_echo <= !pick_echo;
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/uart_rx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_rx (
    input  logic clk,
    input  logic reset,
    input  logic rx,
    output logic [uart_cfg_pkg::data_bits-1:0] data,
    output logic done,
    output logic parity_error
);

    logic rx_meta;
    logic rx_sync;
    logic rx_prev;
    logic active;
    logic [uart_cfg_pkg::clk_cnt_w-1:0] clk_cnt;
    logic [uart_cfg_pkg::bit_idx_w-1:0] bit_idx;
    // data bits land LSB first, the parity bit ends up on top
    logic [uart_cfg_pkg::data_bits:0] shift_sr;
    logic sample;
    logic parity_ok;

    assign sample = active && (clk_cnt == uart_cfg_pkg::bit_last);
    assign parity_ok = ((^shift_sr) == !uart_cfg_pkg::parity_even);
    assign data = shift_sr[uart_cfg_pkg::data_bits-1:0];

    // two flops bring rx into the clock domain, the third gives the edge
    always_ff @(posedge clk) begin
        if (reset) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            active <= 1'b0;
            clk_cnt <= '0;
            bit_idx <= '0;
            done <= 1'b0;
            parity_error <= 1'b0;
        end else begin
            done <= 1'b0;
            parity_error <= 1'b0;
            if (!active) begin
                // starting half way through the count puts each sample at mid-bit
                if (rx_prev && !rx_sync) begin
                    active <= 1'b1;
                    clk_cnt <= uart_cfg_pkg::bit_half;
                    bit_idx <= '0;
                end
            end else if (sample) begin
                clk_cnt <= '0;
                bit_idx <= bit_idx + 1'b1;
                if (bit_idx == '0) begin
                    // a start bit that is high again at mid-bit was only a glitch
                    if (rx_sync) begin
                        active <= 1'b0;
                    end
                end else if (bit_idx == uart_cfg_pkg::stop_idx) begin
                    active <= 1'b0;
                    if (!parity_ok) begin
                        parity_error <= 1'b1;
                    end else if (rx_sync) begin
                        done <= 1'b1;
                    end
                end
            end else begin
                clk_cnt <= clk_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (sample && bit_idx != '0 && bit_idx <= uart_cfg_pkg::parity_idx) begin
            shift_sr <= {rx_sync, shift_sr[uart_cfg_pkg::data_bits:1]};
        end
    end

endmodule

`default_nettype wire

//--- rtl/uart_tx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_tx (
    input  logic clk,
    input  logic reset,
    input  logic start,
    input  logic [uart_cfg_pkg::data_bits-1:0] data,
    output logic tx,
    output logic busy
);

    logic [uart_cfg_pkg::frame_bits-1:0] frame_sr;
    logic [uart_cfg_pkg::clk_cnt_w-1:0] clk_cnt;
    logic [uart_cfg_pkg::bit_idx_w-1:0] bit_idx;
    logic parity;
    logic bit_end;

    // parity is worked out once, when the frame is loaded
    assign parity = (^data) ^ ~uart_cfg_pkg::parity_even;

    assign bit_end = (clk_cnt == uart_cfg_pkg::bit_last);

    // the line idles high, and bit 0 of the frame is always on the wire while busy
    assign tx = busy ? frame_sr[0] : 1'b1;

    always_ff @(posedge clk) begin
        if (reset) begin
            busy <= 1'b0;
            clk_cnt <= '0;
            bit_idx <= '0;
        end else if (!busy) begin
            if (start) begin
                busy <= 1'b1;
                clk_cnt <= '0;
                bit_idx <= '0;
            end
        end else if (bit_end) begin
            clk_cnt <= '0;
            // busy falls at the end of the stop bit
            if (bit_idx == uart_cfg_pkg::stop_idx) begin
                busy <= 1'b0;
            end else begin
                bit_idx <= bit_idx + 1'b1;
            end
        end else begin
            clk_cnt <= clk_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (start && !busy) begin
            frame_sr <= {1'b1, parity, data, 1'b0};
        end else if (busy && bit_end) begin
            // ones shift in behind the stop bit
            frame_sr <= {1'b1, frame_sr[uart_cfg_pkg::frame_bits-1:1]};
        end
    end

endmodule

`default_nettype wire

//--- rtl/tx_req_if.sv
`timescale 1ns/1ps
`default_nettype none

// one requester's byte on its way to the transmit arbiter
interface tx_req_if;

    logic req;
    logic [uart_cfg_pkg::data_bits-1:0] data;
    logic grant;
    // pulses when the granted byte's stop bit has left the line
    logic sent;

    modport requester (
        output req,
        output data,
        input  grant,
        input  sent
    );

    modport arbiter (
        input  req,
        input  data,
        output grant,
        output sent
    );

endinterface

`default_nettype wire

//--- rtl/uart_msg_pkg.sv
`default_nettype none

package uart_msg_pkg;

    // payload bits below the 2-bit kind field
    localparam int code_w = 6;

    // byte kinds, held in the top two bits of every link byte
    localparam logic [1:0] kind_code = 2'd0;
    localparam logic [1:0] kind_echo = 2'd1;
    localparam logic [1:0] kind_set_code = 2'd2;
    localparam logic [1:0] kind_stream_ctl = 2'd3;

    typedef struct packed {
        logic [1:0] kind;
        logic [code_w-1:0] payload;
    } link_fields_t;

    // one link byte, seen either as the raw word or split into kind and payload
    typedef union packed {
        logic [code_w+1:0] raw;
        link_fields_t f;
    } link_byte_u;

endpackage

`default_nettype wire

//--- rtl/uart_cfg_pkg.sv
`default_nettype none

package uart_cfg_pkg;

    // serial bit timing, a 1 Mbaud link on a 48 MHz clock
    localparam int clks_per_bit = 48;
    localparam int clk_cnt_w = $clog2(clks_per_bit);
    localparam logic [clk_cnt_w-1:0] bit_last = clk_cnt_w'(clks_per_bit - 1);
    localparam logic [clk_cnt_w-1:0] bit_half = clk_cnt_w'(clks_per_bit / 2);

    // frame is start, data, parity, stop
    localparam int data_bits = 8;
    localparam int frame_bits = data_bits + 3;
    localparam int bit_idx_w = $clog2(frame_bits);
    localparam logic [bit_idx_w-1:0] parity_idx = bit_idx_w'(data_bits + 1);
    localparam logic [bit_idx_w-1:0] stop_idx = bit_idx_w'(frame_bits - 1);

    // even parity: ones in data plus parity bit come out even
    localparam logic parity_even = 1'b1;

    // delay from reset release to the first streamed code
    localparam int startup_cycles = 64;
    localparam int startup_w = $clog2(startup_cycles);
    localparam logic [startup_w-1:0] startup_last = startup_w'(startup_cycles - 1);

endpackage

`default_nettype wire
